// File: filelist.f
verilog/videoPkg.sv
verilog/videoMemory.sv
verilog/vramArbiter.sv
verilog/hostBridge.sv
verilog/lineRenderer.sv
verilog/graphicsTop.sv
testbench/graphicsTb.sv

// File: testbench/graphicsInput.txt
# W addr data strb resp | R addr data resp | L lines
# all fields hex except the line count of L which is decimal
W FF48 0000003A 1 0
R FF48 0000003A 0
W FF48 00000011 2 0
R FF48 0000003A 0
W FF44 000000F5 1 0
R FF44 00000035 0
W FF4C 000000E4 1 0
W FF4C 000000FF E 0
R FF4C 000000E4 0
W 8000 00001234 3 0
W 8000 0000AB00 2 0
R 8000 0000AB34 0
W 8204 00002211 3 0
W 8204 00000066 1 0
R 8204 00002266 0
W 8200 00000503 3 0
W 8200 0000C700 2 0
R 8200 0000C703 0
R 1234 00000000 3
W 8400 DEADBEEF 3 3
R 8400 00000000 3
W FF50 00000001 1 3
R FF41 00000000 3
W FF40 000000A1 1 0
R FF40 000000A1 0
L 3
W FF48 00000005 1 0
L 32

// File: testbench/graphicsTb.sv
`timescale 1ns/100ps
`default_nettype none

module graphicsTb;
   import videoPkg::*;

   localparam int WAIT_LIMIT = 400;   // cycles any single wait may take

   logic db;
   logic rst;
   logic [15:0] awaddr;
   logic awvalid;
   logic awready;
   logic [31:0] wdata;
   logic [3:0] wstrb;
   logic wvalid;
   logic wready;
   logic [1:0] bresp;
   logic bvalid;
   logic bready;
   logic [15:0] araddr;
   logic arvalid;
   logic arready;
   logic [31:0] rdata;
   logic [1:0] rresp;
   logic rvalid;
   logic rready;
   logic drawLine;
   logic pixelValid;
   logic [X_BITS-1:0] pixelX;
   logic [Y_BITS-1:0] pixelY;
   logic [1:0] shade;
   logic lineDone;
   logic frameDone;

   logic [15:0] shadowMem [0:VRAM_WORDS-1];
   logic [7:0] shadowControl;
   logic [7:0] shadowScrollX;
   logic [7:0] shadowScrollY;
   logic [7:0] shadowPalette;
   int mismatchCount;
   int timeoutCount;
   int setupErrors;
   int expX;
   int tbLine;
   int seedValue;

   graphicsTop graphicsTop_inst (.*);

   always #5 db = ~db;

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
      if (actual !== expected)
      begin
         $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         mismatchCount++;
      end
   endtask

   // background pixel from the shadow copy of memory and registers
   function automatic logic [1:0] expectedShade(input int x, input int y);
      int bgX;
      int bgY;
      int entryIndex;
      int col;
      int colour;
      logic [15:0] mapWord;
      logic [7:0] entry;
      logic [15:0] rowWord;
      bgX = (x + shadowScrollX) % (MAP_TILES * TILE_SIZE);
      bgY = (y + shadowScrollY) % (MAP_TILES * TILE_SIZE);
      entryIndex = (bgY / TILE_SIZE) * MAP_TILES + bgX / TILE_SIZE;
      mapWord = shadowMem[MAP_BASE + entryIndex / 2];
      entry = (entryIndex % 2) ? mapWord[15:8] : mapWord[7:0];
      rowWord = shadowMem[TILE_BASE + 8 * (entry % 16) + bgY % 8];
      col = bgX % 8;
      colour = 2 * rowWord[15 - col] + rowWord[7 - col];   // planeHi sits in the upper byte
      return shadowPalette[2 * colour +: 2];
   endfunction

   // read data the host should see for an address, from the shadow copy
   function automatic logic [31:0] modelReadData(input logic [15:0] addr);
      logic [31:0] value;
      value = 32'h0;
      if (addr >= VRAM_BUS_BASE && int'(addr) < int'(VRAM_BUS_BASE) + 4 * VRAM_WORDS)
         value = {16'h0, shadowMem[(addr - VRAM_BUS_BASE) / 4]};
      else
      begin
         case (addr)
            REG_CONTROL_ADDR: value = {24'h0, shadowControl};
            REG_SCROLLY_ADDR: value = {24'h0, shadowScrollY};
            REG_SCROLLX_ADDR: value = {24'h0, shadowScrollX};
            REG_PALETTE_ADDR: value = {24'h0, shadowPalette};
            default: value = 32'h0;   // unmapped reads return zero
         endcase
      end
      return value;
   endfunction

   task automatic recordWrite(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      int word;
      if (addr >= VRAM_BUS_BASE && int'(addr) < int'(VRAM_BUS_BASE) + 4 * VRAM_WORDS)
      begin
         word = (addr - VRAM_BUS_BASE) / 4;
         if (strb[0])
            shadowMem[word][7:0] = data[7:0];
         if (strb[1])
            shadowMem[word][15:8] = data[15:8];
      end
      else if (strb[0])
      begin
         case (addr)
            REG_CONTROL_ADDR: shadowControl = data[7:0];
            REG_SCROLLY_ADDR: shadowScrollY = data[7:0] & 8'h3F;
            REG_SCROLLX_ADDR: shadowScrollX = data[7:0] & 8'h3F;
            REG_PALETTE_ADDR: shadowPalette = data[7:0];
            default: shadowControl = shadowControl;   // unmapped writes change nothing
         endcase
      end
   endtask

   task automatic writeAxi(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
      int waited;
      resp = 2'bxx;
      @(posedge db);
      #1;
      awaddr = addr;
      wdata = data;
      wstrb = strb;
      awvalid = 1'b1;
      wvalid = 1'b1;
      bready = 1'b1;
      waited = 0;
      do
      begin
         @(negedge db);
         waited++;
      end while (!(awready && wready) && waited < WAIT_LIMIT);
      if (!(awready && wready))
      begin
         $display("timeout waiting for awready at address %h", addr);
         timeoutCount++;
      end
      @(posedge db);
      #1;
      awvalid = 1'b0;
      wvalid = 1'b0;
      waited = 0;
      do
      begin
         @(negedge db);
         waited++;
      end while (!bvalid && waited < WAIT_LIMIT);
      if (bvalid)
         resp = bresp;
      else
      begin
         $display("timeout waiting for bvalid at address %h", addr);
         timeoutCount++;
      end
      @(posedge db);
      #1;
      bready = 1'b0;
   endtask

   task automatic readAxi(input logic [15:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
      int waited;
      data = 'x;
      resp = 2'bxx;
      @(posedge db);
      #1;
      araddr = addr;
      arvalid = 1'b1;
      rready = 1'b1;
      waited = 0;
      do
      begin
         @(negedge db);
         waited++;
      end while (!arready && waited < WAIT_LIMIT);
      if (!arready)
      begin
         $display("timeout waiting for arready at address %h", addr);
         timeoutCount++;
      end
      @(posedge db);
      #1;
      arvalid = 1'b0;
      waited = 0;
      do
      begin
         @(negedge db);
         waited++;
      end while (!rvalid && waited < WAIT_LIMIT);
      if (rvalid)
      begin
         data = rdata;
         resp = rresp;
      end
      else
      begin
         $display("timeout waiting for rvalid at address %h", addr);
         timeoutCount++;
      end
      @(posedge db);
      #1;
      rready = 1'b0;
   endtask

   task automatic fillMemory();
      logic [1:0] resp;
      logic [15:0] pattern;
      for (int w = 0; w < VRAM_WORDS; w++)
      begin
         pattern = {8'(w ^ 8'hC3), 8'(w * 7 + 3)};
         writeAxi(16'(int'(VRAM_BUS_BASE) + 4 * w), {16'h0, pattern}, 4'b0011, resp);
         recordWrite(16'(int'(VRAM_BUS_BASE) + 4 * w), {16'h0, pattern}, 4'b0011);
         checkValue(resp, RESP_OKAY, "fill write response");
      end
   endtask

   task automatic drawLines(input int count);
      int waited;
      for (int i = 0; i < count; i++)
      begin
         @(posedge db);
         #1;
         drawLine = 1'b1;
         @(posedge db);
         #1;
         drawLine = 1'b0;
         waited = 0;
         do
         begin
            @(negedge db);
            waited++;
         end while (!lineDone && waited < WAIT_LIMIT);
         if (!lineDone)
         begin
            $display("timeout waiting for lineDone");
            timeoutCount++;
         end
      end
   endtask

   // host reads that compete with the renderer for the memory port
   task automatic readWhileDrawing();
      int word;
      logic [31:0] data;
      logic [1:0] resp;
      for (int n = 0; n < 4; n++)
      begin
         repeat ($urandom_range(0, 12)) @(posedge db);
         word = $urandom % VRAM_WORDS;
         readAxi(16'(int'(VRAM_BUS_BASE) + 4 * word), data, resp);
         checkValue(data, {16'h0, shadowMem[word]},
                    $sformatf("read of word %h during render", word));
         checkValue(resp, RESP_OKAY, "read response during render");
      end
   endtask

   always @(negedge db)
   begin
      if (!rst && pixelValid)
      begin
         checkValue(pixelX, expX, "pixelX order");
         checkValue(pixelY, tbLine, "pixelY");
         checkValue(shade, expectedShade(expX, tbLine), $sformatf("shade at x %0d", expX));
         expX++;
      end
      if (!rst && lineDone)
      begin
         checkValue(expX, LINE_WIDTH, "pixels in line");
         checkValue(frameDone, tbLine == NUM_LINES - 1, $sformatf("frameDone on line %0d", tbLine));
         tbLine = (tbLine + 1) % NUM_LINES;
         expX = 0;
      end
      else if (!rst && frameDone)
         checkValue(frameDone, 1'b0, "frameDone without lineDone");
   end

   initial
   begin
      int fd;
      int fields;
      int count;
      logic [8*120-1:0] lineBuf;
      logic [7:0] cmd;
      logic [15:0] addr;
      logic [31:0] data;
      logic [31:0] readData;
      logic [3:0] strb;
      logic [1:0] expResp;
      logic [1:0] resp;
      logic sawOutput;
      db = 1'b0;
      rst = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      drawLine = 1'b0;
      mismatchCount = 0;
      timeoutCount = 0;
      setupErrors = 0;
      expX = 0;
      tbLine = 0;
      shadowControl = '0;
      shadowScrollX = '0;
      shadowScrollY = '0;
      shadowPalette = '0;
      seedValue = $urandom(7);
      repeat (5) @(posedge db);
      #1;
      rst = 1'b0;
      @(negedge db);
      checkValue(bvalid, 1'b0, "bvalid after reset");
      checkValue(rvalid, 1'b0, "rvalid after reset");
      checkValue(pixelValid, 1'b0, "pixelValid after reset");
      checkValue(lineDone, 1'b0, "lineDone after reset");
      checkValue(frameDone, 1'b0, "frameDone after reset");
      checkValue(arready, 1'b1, "arready after reset");

      // display is still disabled so this pulse must be ignored
      @(posedge db);
      #1;
      drawLine = 1'b1;
      @(posedge db);
      #1;
      drawLine = 1'b0;
      sawOutput = 1'b0;
      repeat (40)
      begin
         @(negedge db);
         sawOutput = sawOutput | pixelValid | lineDone;
      end
      checkValue(sawOutput, 1'b0, "pixel output while display disabled");

      fillMemory();

      fd = $fopen("testbench/graphicsInput.txt", "r");
      if (fd == 0)
      begin
         $display("could not open testbench/graphicsInput.txt");
         setupErrors++;
      end
      else
      begin
         lineBuf = '0;
         while ($fgets(lineBuf, fd))
         begin
            cmd = 8'h00;
            fields = $sscanf(lineBuf, "%s", cmd);
            if (fields > 0 && cmd == "W")
            begin
               fields = $sscanf(lineBuf, "%s %h %h %h %h", cmd, addr, data, strb, expResp);
               writeAxi(addr, data, strb, resp);
               recordWrite(addr, data, strb);
               checkValue(resp, expResp, $sformatf("write response at %h", addr));
            end
            else if (fields > 0 && cmd == "R")
            begin
               fields = $sscanf(lineBuf, "%s %h %h %h", cmd, addr, data, expResp);
               readAxi(addr, readData, resp);
               checkValue(readData, data, $sformatf("read data at %h", addr));
               checkValue(readData, modelReadData(addr),
                          $sformatf("read data at %h against shadow copy", addr));
               checkValue(resp, expResp, $sformatf("read response at %h", addr));
            end
            else if (fields > 0 && cmd == "L")
            begin
               fields = $sscanf(lineBuf, "%s %d", cmd, count);
               fork
                  drawLines(count);
                  readWhileDrawing();
               join
            end
            else if (fields > 0 && cmd != "#")
            begin
               $display("unknown command in input file: %0s", lineBuf);
               setupErrors++;
            end
            lineBuf = '0;
         end
         $fclose(fd);
      end

      repeat (5) @(posedge db);
      $display("mismatches: %0d  timeouts: %0d  other failures: %0d",
               mismatchCount, timeoutCount, setupErrors);
      if (mismatchCount == 0 && timeoutCount == 0 && setupErrors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/graphicsTop.sv
`timescale 1ns/100ps
`default_nettype none

module graphicsTop (
   input  logic                        db,
   input  logic                        rst,
   input  logic [15:0]                 awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [31:0]                 wdata,
   input  logic [3:0]                  wstrb,
   input  logic                        wvalid,
   output logic                        wready,
   output logic [1:0]                  bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [15:0]                 araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [31:0]                 rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   input  logic                        drawLine,
   output logic                        pixelValid,
   output logic [videoPkg::X_BITS-1:0] pixelX,
   output logic [videoPkg::Y_BITS-1:0] pixelY,
   output logic [1:0]                  shade,
   output logic                        lineDone,
   output logic                        frameDone
);
   import videoPkg::*;

   logic hostReq;
   logic [VRAM_ADDR_BITS-1:0] hostAddr;
   logic hostWrite;
   logic [1:0] hostByteEnable;
   logic [15:0] hostWriteData;
   logic hostGrant;
   logic renderReq;
   logic [VRAM_ADDR_BITS-1:0] renderAddr;
   logic renderGrant;
   logic [VRAM_ADDR_BITS-1:0] memAddr;
   logic memWriteEnable;
   logic [1:0] memByteEnable;
   logic [15:0] memWriteData;
   logic [15:0] memReadData;   // shared by both requesters
   logic lcdEnable;
   logic [BG_BITS-1:0] scrollX;
   logic [BG_BITS-1:0] scrollY;
   logic [7:0] bgPalette;

   hostBridge hostBridgeInst (.*);

   lineRenderer lineRendererInst (.*);

   vramArbiter vramArbiterInst (.*);

   videoMemory videoMemoryInst (
      .db          (db),
      .addr        (memAddr),
      .writeEnable (memWriteEnable),
      .byteEnable  (memByteEnable),
      .writeData   (memWriteData),
      .readData    (memReadData)
   );

endmodule

`default_nettype wire

// File: verilog/hostBridge.sv
`timescale 1ns/100ps
`default_nettype none

module hostBridge (
   input  logic                                db,
   input  logic                                rst,
   input  logic [15:0]                         awaddr,
   input  logic                                awvalid,
   output logic                                awready,
   input  logic [31:0]                         wdata,
   input  logic [3:0]                          wstrb,
   input  logic                                wvalid,
   output logic                                wready,
   output logic [1:0]                          bresp,
   output logic                                bvalid,
   input  logic                                bready,
   input  logic [15:0]                         araddr,
   input  logic                                arvalid,
   output logic                                arready,
   output logic [31:0]                         rdata,
   output logic [1:0]                          rresp,
   output logic                                rvalid,
   input  logic                                rready,
   output logic                                hostReq,
   output logic [videoPkg::VRAM_ADDR_BITS-1:0] hostAddr,
   output logic                                hostWrite,
   output logic [1:0]                          hostByteEnable,
   output logic [15:0]                         hostWriteData,
   input  logic                                hostGrant,
   input  logic [15:0]                         memReadData,
   output logic                                lcdEnable,
   output logic [videoPkg::BG_BITS-1:0]        scrollX,
   output logic [videoPkg::BG_BITS-1:0]        scrollY,
   output logic [7:0]                          bgPalette
);
   import videoPkg::*;

   logic [1:0] state;
   logic [7:0] controlReg;
   logic [7:0] regReadData;
   logic regReadHit;
   logic readAccept;
   logic writeAccept;
   logic captureNow;
   logic [31:0] rdataReg;

   function automatic logic isVram(input logic [15:0] addr);
      return (addr >= VRAM_BUS_BASE) && (addr < VRAM_BUS_LIMIT);
   endfunction

   assign arready = state == BRIDGE_IDLE;
   assign awready = (state == BRIDGE_IDLE) && awvalid && wvalid && !arvalid;   // reads go first
   assign wready = awready;
   assign readAccept = arvalid && arready;
   assign writeAccept = awvalid && awready;
   assign hostReq = state == BRIDGE_MEM_WAIT;
   assign lcdEnable = controlReg[0];
   assign rdata = captureNow ? {16'b0, memReadData} : rdataReg;   // memory word is live the cycle after grant

   always_comb
   begin
      regReadHit = 1'b1;
      case (araddr)
         REG_CONTROL_ADDR: regReadData = controlReg;
         REG_SCROLLY_ADDR: regReadData = 8'(scrollY);
         REG_SCROLLX_ADDR: regReadData = 8'(scrollX);
         REG_PALETTE_ADDR: regReadData = bgPalette;
         default:
         begin
            regReadHit = 1'b0;
            regReadData = 8'h00;
         end
      endcase
   end

   always_ff @(posedge db)
   begin
      if (rst)
      begin
         state <= BRIDGE_IDLE;
         bvalid <= 1'b0;
         rvalid <= 1'b0;
         bresp <= RESP_OKAY;
         rresp <= RESP_OKAY;
         captureNow <= 1'b0;
         hostWrite <= 1'b0;
         controlReg <= '0;
         scrollX <= '0;
         scrollY <= '0;
         bgPalette <= '0;
      end
      else
      begin
         captureNow <= 1'b0;
         case (state)
            BRIDGE_IDLE:
               if (readAccept)
               begin
                  if (isVram(araddr))
                  begin
                     hostAddr <= araddr[VRAM_ADDR_BITS+1:2];
                     hostWrite <= 1'b0;
                     state <= BRIDGE_MEM_WAIT;
                  end
                  else
                  begin
                     rdataReg <= 32'(regReadData);
                     rresp <= regReadHit ? RESP_OKAY : RESP_DECERR;
                     rvalid <= 1'b1;
                     state <= BRIDGE_READ_DATA;
                  end
               end
               else if (writeAccept)
               begin
                  if (isVram(awaddr))
                  begin
                     hostAddr <= awaddr[VRAM_ADDR_BITS+1:2];
                     hostWrite <= 1'b1;
                     hostByteEnable <= wstrb[1:0];
                     hostWriteData <= wdata[15:0];
                     state <= BRIDGE_MEM_WAIT;
                  end
                  else
                  begin
                     bresp <= RESP_OKAY;
                     case (awaddr)   // all registers live in byte lane 0
                        REG_CONTROL_ADDR: if (wstrb[0]) controlReg <= wdata[7:0];
                        REG_SCROLLY_ADDR: if (wstrb[0]) scrollY <= wdata[BG_BITS-1:0];
                        REG_SCROLLX_ADDR: if (wstrb[0]) scrollX <= wdata[BG_BITS-1:0];
                        REG_PALETTE_ADDR: if (wstrb[0]) bgPalette <= wdata[7:0];
                        default: bresp <= RESP_DECERR;
                     endcase
                     bvalid <= 1'b1;
                     state <= BRIDGE_WRITE_RESP;
                  end
               end
            BRIDGE_MEM_WAIT:
               if (hostGrant)
               begin
                  if (hostWrite)
                  begin
                     bresp <= RESP_OKAY;
                     bvalid <= 1'b1;
                     state <= BRIDGE_WRITE_RESP;
                  end
                  else
                  begin
                     rresp <= RESP_OKAY;
                     rvalid <= 1'b1;
                     captureNow <= 1'b1;
                     state <= BRIDGE_READ_DATA;
                  end
               end
            BRIDGE_READ_DATA:
            begin
               if (captureNow)
                  rdataReg <= {16'b0, memReadData};   // hold it while rready is low
               if (rready)
               begin
                  rvalid <= 1'b0;
                  state <= BRIDGE_IDLE;
               end
            end
            default:
               if (bready)
               begin
                  bvalid <= 1'b0;
                  state <= BRIDGE_IDLE;
               end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/lineRenderer.sv
`timescale 1ns/100ps
`default_nettype none

module lineRenderer (
   input  logic                                db,
   input  logic                                rst,
   input  logic                                drawLine,
   input  logic                                lcdEnable,
   input  logic [videoPkg::BG_BITS-1:0]        scrollX,
   input  logic [videoPkg::BG_BITS-1:0]        scrollY,
   input  logic [7:0]                          bgPalette,
   output logic                                renderReq,
   output logic [videoPkg::VRAM_ADDR_BITS-1:0] renderAddr,
   input  logic                                renderGrant,
   input  logic [15:0]                         memReadData,
   output logic                                pixelValid,
   output logic [videoPkg::X_BITS-1:0]         pixelX,
   output logic [videoPkg::Y_BITS-1:0]         pixelY,
   output logic [1:0]                          shade,
   output logic                                lineDone,
   output logic                                frameDone
);
   import videoPkg::*;

   logic [2:0] state;
   logic [X_BITS-1:0] xPos;
   logic [Y_BITS-1:0] lineCount;
   logic [BG_BITS-1:0] bgX;
   logic [BG_BITS-1:0] bgY;
   logic [BG_BITS-1:0] fetchBgX;
   logic [ROW_BITS-1:0] col;
   vramWord fetchWord;
   tileRow tileCache;
   logic [7:0] mapEntry;
   logic [1:0] colour;
   logic lastPixel;
   logic lastInTile;

   assign bgX = BG_BITS'(xPos) + scrollX;
   assign bgY = BG_BITS'(lineCount) + scrollY;
   assign fetchBgX = (state == REND_EMIT) ? bgX + BG_BITS'(1) : bgX;   // emit prefetches the next tile
   assign col = bgX[ROW_BITS-1:0];
   assign fetchWord = memReadData;
   assign mapEntry = bgX[ROW_BITS] ? fetchWord.pair.entryOdd : fetchWord.pair.entryEven;
   assign colour = {tileCache.planeHi[3'd7 - col], tileCache.planeLo[3'd7 - col]};
   assign lastPixel = xPos == X_BITS'(LINE_WIDTH - 1);
   assign lastInTile = col == ROW_BITS'(TILE_SIZE - 1);

   always_comb
   begin
      renderReq = 1'b0;
      renderAddr = MAP_BASE +
         VRAM_ADDR_BITS'({bgY[BG_BITS-1:ROW_BITS], fetchBgX[BG_BITS-1:ROW_BITS+1]});
      case (state)
         REND_MAP_REQ: renderReq = 1'b1;
         REND_EMIT: renderReq = lastInTile && !lastPixel;
         REND_MAP_DATA:
         begin
            // the map word arrives now, so the tile row is asked for at once
            renderReq = 1'b1;
            renderAddr = TILE_BASE + VRAM_ADDR_BITS'({mapEntry[3:0], bgY[ROW_BITS-1:0]});
         end
         default: renderReq = 1'b0;
      endcase
   end

   always_ff @(posedge db)
   begin
      if (rst)
      begin
         state <= REND_IDLE;
         xPos <= '0;
         lineCount <= '0;
         pixelValid <= 1'b0;
         lineDone <= 1'b0;
         frameDone <= 1'b0;
      end
      else
      begin
         pixelValid <= 1'b0;
         lineDone <= 1'b0;
         frameDone <= 1'b0;
         case (state)
            REND_IDLE:
               if (drawLine && lcdEnable)
               begin
                  xPos <= '0;
                  state <= REND_MAP_REQ;
               end
            REND_MAP_REQ:
               if (renderGrant)
                  state <= REND_MAP_DATA;
            REND_MAP_DATA:
               if (renderGrant)
                  state <= REND_TILE_DATA;
            REND_TILE_DATA: state <= REND_EMIT;
            REND_EMIT:
            begin
               pixelValid <= 1'b1;
               xPos <= xPos + 1'b1;
               if (lastPixel)
               begin
                  lineDone <= 1'b1;
                  frameDone <= lineCount == Y_BITS'(NUM_LINES - 1);
                  lineCount <= lineCount + 1'b1;   // wraps to line 0 after the frame
                  state <= REND_IDLE;
               end
               else if (lastInTile)
                  state <= renderGrant ? REND_MAP_DATA : REND_MAP_REQ;
            end
            default: state <= REND_IDLE;
         endcase
      end
   end

   always_ff @(posedge db)
   begin
      if (state == REND_TILE_DATA)
         tileCache <= fetchWord.row;
      if (state == REND_EMIT)
      begin
         pixelX <= xPos;
         pixelY <= lineCount;
         shade <= bgPalette[2 * colour +: 2];
      end
   end

endmodule

`default_nettype wire

// File: verilog/videoMemory.sv
`timescale 1ns/100ps
`default_nettype none

module videoMemory (
   input  logic                                db,
   input  logic [videoPkg::VRAM_ADDR_BITS-1:0] addr,
   input  logic                                writeEnable,
   input  logic [1:0]                          byteEnable,
   input  logic [15:0]                         writeData,
   output logic [15:0]                         readData
);
   import videoPkg::*;

   logic [15:0] mem [0:VRAM_WORDS-1];

   always_ff @(posedge db)
   begin
      if (writeEnable)
      begin
         if (byteEnable[0])
            mem[addr][7:0] <= writeData[7:0];
         if (byteEnable[1])
            mem[addr][15:8] <= writeData[15:8];
      end
      readData <= mem[addr];   // old contents on a write cycle
   end

endmodule

`default_nettype wire

// File: verilog/videoPkg.sv
`default_nettype none

package videoPkg;

   // screen and background geometry
   localparam int LINE_WIDTH = 32;
   localparam int NUM_LINES = 32;
   localparam int TILE_SIZE = 8;
   localparam int MAP_TILES = 8;

   localparam int X_BITS = $clog2(LINE_WIDTH);
   localparam int Y_BITS = $clog2(NUM_LINES);
   localparam int ROW_BITS = $clog2(TILE_SIZE);
   localparam int BG_BITS = $clog2(MAP_TILES * TILE_SIZE);   // background wraps at 64 pixels

   // video memory layout
   localparam int VRAM_ADDR_BITS = 8;
   localparam int VRAM_WORDS = 2 ** VRAM_ADDR_BITS;
   localparam logic [VRAM_ADDR_BITS-1:0] TILE_BASE = 8'h00;   // 16 tiles of 8 rows
   localparam logic [VRAM_ADDR_BITS-1:0] MAP_BASE = 8'h80;   // two map entries per word

   // host byte addresses
   localparam logic [15:0] VRAM_BUS_BASE = 16'h8000;
   localparam logic [15:0] VRAM_BUS_LIMIT = VRAM_BUS_BASE + 16'(4 * VRAM_WORDS);
   localparam logic [15:0] REG_CONTROL_ADDR = 16'hFF40;
   localparam logic [15:0] REG_SCROLLY_ADDR = 16'hFF44;
   localparam logic [15:0] REG_SCROLLX_ADDR = 16'hFF48;
   localparam logic [15:0] REG_PALETTE_ADDR = 16'hFF4C;

   localparam logic [1:0] RESP_OKAY = 2'd0;
   localparam logic [1:0] RESP_DECERR = 2'd3;

   // host bridge states
   localparam logic [1:0] BRIDGE_IDLE = 2'd0;
   localparam logic [1:0] BRIDGE_MEM_WAIT = 2'd1;
   localparam logic [1:0] BRIDGE_READ_DATA = 2'd2;
   localparam logic [1:0] BRIDGE_WRITE_RESP = 2'd3;

   // renderer states
   localparam logic [2:0] REND_IDLE = 3'd0;
   localparam logic [2:0] REND_MAP_REQ = 3'd1;
   localparam logic [2:0] REND_MAP_DATA = 3'd2;
   localparam logic [2:0] REND_TILE_DATA = 3'd3;
   localparam logic [2:0] REND_EMIT = 3'd4;

   typedef struct packed {
      logic [7:0] planeHi;
      logic [7:0] planeLo;
   } tileRow;

   typedef struct packed {
      logic [7:0] entryOdd;
      logic [7:0] entryEven;
   } mapPair;

   // one memory word seen either as a tile row or as two map entries
   typedef union packed {
      tileRow row;
      mapPair pair;
   } vramWord;

endpackage

`default_nettype wire

// File: verilog/vramArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module vramArbiter (
   input  logic                                renderReq,
   input  logic [videoPkg::VRAM_ADDR_BITS-1:0] renderAddr,
   output logic                                renderGrant,
   input  logic                                hostReq,
   input  logic [videoPkg::VRAM_ADDR_BITS-1:0] hostAddr,
   input  logic                                hostWrite,
   input  logic [1:0]                          hostByteEnable,
   input  logic [15:0]                         hostWriteData,
   output logic                                hostGrant,
   output logic [videoPkg::VRAM_ADDR_BITS-1:0] memAddr,
   output logic                                memWriteEnable,
   output logic [1:0]                          memByteEnable,
   output logic [15:0]                         memWriteData
);

   // renderer has fixed priority, the host waits while it asks
   assign renderGrant = renderReq;
   assign hostGrant = hostReq && !renderReq;

   assign memAddr = renderReq ? renderAddr : hostAddr;
   assign memWriteEnable = hostGrant && hostWrite;   // renderer path is read only
   assign memByteEnable = hostGrant ? hostByteEnable : 2'b00;
   assign memWriteData = hostWriteData;

endmodule

`default_nettype wire
